// ==== logic/rop_params.svh ====
/*
 * ROP co-processor encoding constants
 * Major opcode, funct3 and funct7 values, writeback codes
 */

`ifndef ROP_PARAMS_SVH
`define ROP_PARAMS_SVH

// ISE major opcode space
`define ROP_ISE_OPCODE  7'b0101011

// funct3 field values
`define ROP_F3_SB_B     3'b000      // Byte store
`define ROP_F3_R        3'b001      // R-type logic group
`define ROP_F3_LB_B     3'b010      // Byte load
`define ROP_F3_LB_BK    3'b011      // Byte load, keep padding

// funct7 field values inside the R-type group
`define ROP_F7_XOR_RB   7'b0000000
`define ROP_F7_XOR_RBK  7'b0000001
`define ROP_F7_AND_RB   7'b0000010
`define ROP_F7_AND_RBK  7'b0000011
`define ROP_F7_OR_RB    7'b0000100
`define ROP_F7_OR_RBK   7'b0000101

`define ROP_AREG_BASE   5'd10       // a0 in the RISC-V ABI
`define ROP_WB_WORD     3'd4        // Destination byte code for a full word

`endif

// ==== logic/rop_pkg.sv ====
/*
 * ROP co-processor shared types
 * Opcode enum and decoded instruction field types
 */

package rop_pkg;

    //--------------------------------------------------
    // Field widths
    //--------------------------------------------------

    localparam int OP_W       = 4;      // Opcode enum width
    localparam int REG_IDX_W  = 5;      // RISC-V register index
    localparam int BYTE_SEL_W = 3;      // Byte code, 4 means full word
    localparam int WORD_W     = 32;     // Register / memory word

    //--------------------------------------------------
    // Types
    //--------------------------------------------------

    // Decoded ISE operation
    typedef enum logic [OP_W-1:0] {
        OP_NONE,        // Not a member, or no request
        OP_SB_B,
        OP_LB_B,
        OP_LB_BK,
        OP_XOR_RB,
        OP_XOR_RBK,
        OP_AND_RB,
        OP_AND_RBK,
        OP_OR_RB,
        OP_OR_RBK
    } rop_op_e;

    typedef logic [REG_IDX_W-1:0]  reg_idx_t;   // Destination register index
    typedef logic [BYTE_SEL_W-1:0] byte_sel_t;  // Destination byte code
    typedef logic [WORD_W-1:0]     word_t;      // Data word

endpackage

// ==== logic/rop_dec_if.sv ====
/*
 * Decoded instruction bundle
 * Carries the decode result to the execute and result stages
 */

interface rop_dec_if;

    rop_pkg::rop_op_e  op;          // Decoded operation
    logic              is_load;     // LB.B or LB.BK
    logic              is_store;    // SB.B
    logic              rand_keep;   // Keep forms, full word writeback
    rop_pkg::word_t    imm;         // Sign-extended S- or I-type offset
    rop_pkg::reg_idx_t rd_field;    // Raw rd field of the instruction

    // Decoder drives every field
    modport decode (
        output op, is_load, is_store, rand_keep, imm, rd_field
    );

    // Operand and memory side
    modport execute (
        input  op, is_load, is_store, imm
    );

    // Writeback side
    modport result (
        input  op, is_load, rand_keep, rd_field
    );

endinterface

// ==== logic/rop_decode.sv ====
/*
 * ROP instruction decoder
 * Maps an offered instruction word onto an opcode, flags and offset
 */

`include "rop_params.svh"

module rop_decode (
    input  logic              cop_req,        // Request valid from the core
    input  rop_pkg::word_t    cop_instr_in,   // Offered instruction word
    rop_dec_if.decode         dec,            // Decoded instruction out
    output logic              cop_acc         // Member of the ISE
);

    //--------------------------------------------------
    // Instruction fields
    //--------------------------------------------------

    logic [6:0]       f_opcode;
    logic [2:0]       f_funct3;
    logic [6:0]       f_funct7;
    logic             in_ise;
    rop_pkg::rop_op_e op_dec;
    rop_pkg::word_t   s_imm;
    rop_pkg::word_t   i_imm;

    assign f_opcode = cop_instr_in[6:0];
    assign f_funct3 = cop_instr_in[14:12];
    assign f_funct7 = cop_instr_in[31:25];

    // Only live requests in our major opcode count
    assign in_ise = cop_req && (f_opcode == `ROP_ISE_OPCODE);

    //--------------------------------------------------
    // Opcode decode
    //--------------------------------------------------

    always_comb begin
        op_dec = rop_pkg::OP_NONE;
        if (in_ise) begin
            case (f_funct3)
                `ROP_F3_SB_B:  op_dec = rop_pkg::OP_SB_B;
                `ROP_F3_LB_B:  op_dec = rop_pkg::OP_LB_B;
                `ROP_F3_LB_BK: op_dec = rop_pkg::OP_LB_BK;
                `ROP_F3_R: begin
                    case (f_funct7)
                        `ROP_F7_XOR_RB:  op_dec = rop_pkg::OP_XOR_RB;
                        `ROP_F7_XOR_RBK: op_dec = rop_pkg::OP_XOR_RBK;
                        `ROP_F7_AND_RB:  op_dec = rop_pkg::OP_AND_RB;
                        `ROP_F7_AND_RBK: op_dec = rop_pkg::OP_AND_RBK;
                        `ROP_F7_OR_RB:   op_dec = rop_pkg::OP_OR_RB;
                        `ROP_F7_OR_RBK:  op_dec = rop_pkg::OP_OR_RBK;
                        default:         op_dec = rop_pkg::OP_NONE;  // Unused funct7
                    endcase
                end
                default: op_dec = rop_pkg::OP_NONE;   // Unused funct3
            endcase
        end
    end

    //--------------------------------------------------
    // Flags and immediate
    //--------------------------------------------------

    // S-type offset for the store, I-type for loads
    assign s_imm = {{20{cop_instr_in[31]}}, cop_instr_in[31:25], cop_instr_in[11:7]};
    assign i_imm = {{20{cop_instr_in[31]}}, cop_instr_in[31:20]};

    assign dec.op        = op_dec;
    assign dec.is_store  = (op_dec == rop_pkg::OP_SB_B);
    assign dec.is_load   = (op_dec == rop_pkg::OP_LB_B) || (op_dec == rop_pkg::OP_LB_BK);
    assign dec.rand_keep = (op_dec == rop_pkg::OP_LB_BK)   ||
                           (op_dec == rop_pkg::OP_XOR_RBK) ||
                           (op_dec == rop_pkg::OP_AND_RBK) ||
                           (op_dec == rop_pkg::OP_OR_RBK);
    assign dec.imm       = (op_dec == rop_pkg::OP_SB_B) ? s_imm : i_imm;
    assign dec.rd_field  = cop_instr_in[11:7];

    // Anything decoded is ours
    assign cop_acc = (op_dec != rop_pkg::OP_NONE);

endmodule

// ==== logic/rop_prng.sv ====
/*
 * ROP padding source
 * 64-bit xorshift generator, steps once per clock
 */

module rop_prng (
    input  logic        clk,
    input  logic        rst_n,          // Sync, active low
    output logic [63:0] rng_random      // Current generator state
);

    // Any nonzero value works, zero locks the generator
    localparam logic [63:0] PRNG_SEED = 64'h9E37_79B9_7F4A_7C15;

    logic [63:0] state;
    logic [63:0] step_a;
    logic [63:0] step_b;
    logic [63:0] state_nxt;

    //--------------------------------------------------
    // Xorshift64 next state, shifts 13 / 7 / 17
    //--------------------------------------------------

    assign step_a    = state  ^ (state  << 13);
    assign step_b    = step_a ^ (step_a >> 7);
    assign state_nxt = step_b ^ (step_b << 17);

    // Free running, no enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PRNG_SEED;
        end else begin
            state <= state_nxt;
        end
    end

    assign rng_random = state;

endmodule

// ==== logic/rop_execute.sv ====
/*
 * ROP execute stage
 * Padded logic operations and the memory port drive
 */

module rop_execute (
    input  logic           clk,
    input  logic           rst_n,
    rop_dec_if.execute     dec,               // Decoded instruction
    input  rop_pkg::word_t cop_rs1,           // Source register 1
    input  rop_pkg::word_t cop_rs2,           // Source register 2
    output rop_pkg::word_t arith_out,         // Padded logic result
    output logic           mem_done,          // Memory operation ends this cycle

    // Memory port
    output logic           cop_mem_cen,
    output logic           cop_mem_wen,
    output logic [3:0]     cop_mem_ben,
    output rop_pkg::word_t cop_mem_wdata,
    output rop_pkg::word_t cop_mem_addr,
    input  logic           cop_mem_stall,
    input  logic           cop_mem_error,
    output logic           cop_mem_ld_error,
    output logic           cop_mem_st_error
);

    logic [63:0]    prng_out;
    rop_pkg::word_t arith_lhs;
    rop_pkg::word_t arith_rhs;
    rop_pkg::word_t mem_addr;
    logic           mem_op;

    //--------------------------------------------------
    // Random padding source
    //--------------------------------------------------

    rop_prng prng_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rng_random (prng_out)
    );

    //--------------------------------------------------
    // Logic operations
    //--------------------------------------------------

    // Real data only in the low byte, upper bits are noise
    assign arith_lhs = {prng_out[31:8],  cop_rs1[7:0]};
    assign arith_rhs = {prng_out[55:32], cop_rs2[7:0]};  // Separate slice from lhs

    always_comb begin
        case (dec.op)
            rop_pkg::OP_XOR_RB,
            rop_pkg::OP_XOR_RBK: arith_out = arith_lhs ^ arith_rhs;
            rop_pkg::OP_AND_RB,
            rop_pkg::OP_AND_RBK: arith_out = arith_lhs & arith_rhs;
            rop_pkg::OP_OR_RB,
            rop_pkg::OP_OR_RBK:  arith_out = arith_lhs | arith_rhs;
            default:             arith_out = '0;     // Memory ops or none
        endcase
    end

    //--------------------------------------------------
    // Memory port
    //--------------------------------------------------

    assign mem_op   = dec.is_load || dec.is_store;
    assign mem_addr = cop_rs1 + dec.imm;              // Byte address

    // Held while pending, dropped on error
    assign cop_mem_cen   = mem_op && !cop_mem_error;
    assign cop_mem_wen   = dec.is_store;
    assign cop_mem_wdata = cop_rs2;
    assign cop_mem_addr  = mem_addr & 32'hFFFF_FFFC;  // Word aligned
    assign cop_mem_ben   = 4'b0001 << mem_addr[1:0];  // One lane per byte offset

    // Error split by direction
    assign cop_mem_ld_error = cop_mem_error && dec.is_load;
    assign cop_mem_st_error = cop_mem_error && dec.is_store;

    // First cycle without stall, or any error, closes the access
    assign mem_done = mem_op && (!cop_mem_stall || cop_mem_error);

endmodule

// ==== logic/rop_result.sv ====
/*
 * ROP result stage
 * Destination register, byte code, writeback data and response
 */

`include "rop_params.svh"

module rop_result (
    rop_dec_if.result          dec,             // Decoded instruction
    input  rop_pkg::word_t     arith_out,       // From execute
    input  rop_pkg::word_t     cop_mem_rdata,   // Memory read data
    input  logic               mem_done,        // Memory access closed
    output rop_pkg::reg_idx_t  cop_rd,
    output rop_pkg::byte_sel_t cop_rd_byte,
    output rop_pkg::word_t     cop_wdata,
    output logic               cop_wen,
    output logic               cop_rsp
);

    logic              arith_op;
    rop_pkg::reg_idx_t areg_rd;

    // Any of the six logic forms
    assign arith_op = (dec.op == rop_pkg::OP_XOR_RB)  ||
                      (dec.op == rop_pkg::OP_XOR_RBK) ||
                      (dec.op == rop_pkg::OP_AND_RB)  ||
                      (dec.op == rop_pkg::OP_AND_RBK) ||
                      (dec.op == rop_pkg::OP_OR_RB)   ||
                      (dec.op == rop_pkg::OP_OR_RBK);

    //--------------------------------------------------
    // Destination mapping
    //--------------------------------------------------

    // Low three rd bits pick one of a0..a7
    assign areg_rd = `ROP_AREG_BASE + {2'b00, dec.rd_field[2:0]};

    assign cop_rd = dec.rand_keep ? areg_rd : dec.rd_field;

    // Byte forms use rd[4:3] as the lane, keep forms write everything
    assign cop_rd_byte = dec.rand_keep ? `ROP_WB_WORD : {1'b0, dec.rd_field[4:3]};

    //--------------------------------------------------
    // Writeback and response
    //--------------------------------------------------

    assign cop_wdata = dec.is_load ? cop_mem_rdata : arith_out;

    // Stores never write a register
    assign cop_wen = arith_op || (dec.is_load && mem_done);

    // Logic ops respond at once, memory ops when the port finishes
    assign cop_rsp = arith_op || mem_done;

endmodule

// ==== logic/rop_ba_cop.sv ====
/*
 * Random operand padded, byte addressable co-processor
 * Core operands must stay stable until cop_rsp
 */

module rop_ba_cop (
    input  logic               clk,               // Core clock
    output logic               clk_req,           // Clock request
    input  logic               rst_n,             // Sync, active low

    // Core request / response
    input  logic               cop_req,
    output logic               cop_acc,
    output logic               cop_rsp,
    input  rop_pkg::word_t     cop_instr_in,
    input  rop_pkg::word_t     cop_rs1,
    input  rop_pkg::word_t     cop_rs2,

    // Writeback
    output rop_pkg::byte_sel_t cop_rd_byte,
    output rop_pkg::reg_idx_t  cop_rd,
    output rop_pkg::word_t     cop_wdata,
    output logic               cop_wen,

    output logic               cop_mem_ld_error,  // Error on a load
    output logic               cop_mem_st_error,  // Error on a store

    // Memory port
    output logic               cop_mem_cen,
    input  logic               cop_mem_stall,
    input  logic               cop_mem_error,
    output logic               cop_mem_wen,
    output logic [3:0]         cop_mem_ben,
    output rop_pkg::word_t     cop_mem_wdata,
    input  rop_pkg::word_t     cop_mem_rdata,
    output rop_pkg::word_t     cop_mem_addr
);

    rop_pkg::word_t arith_out;    // Padded logic result
    logic           mem_done;     // Memory access closes this cycle

    rop_dec_if dec_if ();

    // Only ask for a clock while a request is up
    assign clk_req = cop_req;

    //--------------------------------------------------
    // Decode
    //--------------------------------------------------

    rop_decode decode_inst (
        .cop_req      (cop_req),
        .cop_instr_in (cop_instr_in),
        .dec          (dec_if.decode),
        .cop_acc      (cop_acc)
    );

    //--------------------------------------------------
    // Execute, with the PRNG inside
    //--------------------------------------------------

    rop_execute execute_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec              (dec_if.execute),
        .cop_rs1          (cop_rs1),
        .cop_rs2          (cop_rs2),
        .arith_out        (arith_out),
        .mem_done         (mem_done),
        .cop_mem_cen      (cop_mem_cen),
        .cop_mem_wen      (cop_mem_wen),
        .cop_mem_ben      (cop_mem_ben),
        .cop_mem_wdata    (cop_mem_wdata),
        .cop_mem_addr     (cop_mem_addr),
        .cop_mem_stall    (cop_mem_stall),
        .cop_mem_error    (cop_mem_error),
        .cop_mem_ld_error (cop_mem_ld_error),
        .cop_mem_st_error (cop_mem_st_error)
    );

    //--------------------------------------------------
    // Writeback
    //--------------------------------------------------

    rop_result result_inst (
        .dec           (dec_if.result),
        .arith_out     (arith_out),
        .cop_mem_rdata (cop_mem_rdata),
        .mem_done      (mem_done),
        .cop_rd        (cop_rd),
        .cop_rd_byte   (cop_rd_byte),
        .cop_wdata     (cop_wdata),
        .cop_wen       (cop_wen),
        .cop_rsp       (cop_rsp)
    );

endmodule

// ==== testbench/tb_rop_mem.sv ====
/*
 * Word-wide memory model for the ROP co-processor
 * 256 words, programmable stall cycles and one error address
 */

module tb_rop_mem (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cen,            // Access pending
    input  logic           wen,
    input  logic [3:0]     ben,
    input  rop_pkg::word_t wdata,
    input  rop_pkg::word_t addr,           // Word aligned byte address
    output logic           stall,
    output logic           error,
    output rop_pkg::word_t rdata,
    input  int             stall_cycles,   // Stall length per access
    input  logic           err_en,
    input  rop_pkg::word_t err_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    rop_pkg::word_t mem [0:255];
    int             stall_cnt;             // Stalled cycles so far

    // Fill depends on every index bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203) ^ i;
        end
    end

    assign stall = cen && (stall_cnt < stall_cycles);
    assign error = err_en && (addr == err_addr);   // Address match only, no loop via cen
    assign rdata = mem[addr[9:2]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_cnt <= 0;
        end else if (stall) begin
            stall_cnt <= stall_cnt + 1;
        end else begin
            stall_cnt <= 0;                    // Access done or idle
        end
    end

    // Byte lane write on the closing cycle
    always @(posedge clk) begin
        if (cen && wen && !stall) begin
            for (int k = 0; k < 4; k++) begin
                if (ben[k]) mem[addr[9:2]][8*k +: 8] <= wdata[8*k +: 8];
            end
        end
    end

endmodule

// ==== testbench/tb_rop_ba_cop.sv ====
/*
 * Testbench for the ROP co-processor
 * Directed tests for decode, padded logic ops, mapping and memory
 */

`include "rop_params.svh"

module tb_rop_ba_cop;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RSP_TIMEOUT = 20;       // Cycles allowed per response

    logic clk, clk_req, rst_n, cop_req, cop_acc, cop_rsp, cop_wen;
    logic cop_mem_ld_error, cop_mem_st_error, cop_mem_cen, cop_mem_stall;
    logic cop_mem_error, cop_mem_wen, err_en;
    logic [3:0] cop_mem_ben;
    rop_pkg::word_t cop_instr_in, cop_rs1, cop_rs2, cop_wdata;
    rop_pkg::word_t cop_mem_wdata, cop_mem_rdata, cop_mem_addr, err_addr;
    rop_pkg::reg_idx_t  cop_rd;
    rop_pkg::byte_sel_t cop_rd_byte;
    int stall_cycles;
    int checks = 0;
    int errors = 0;
    rop_pkg::word_t lcg_state = 32'd47963;

    rop_ba_cop rop_ba_cop_inst (.*);

    tb_rop_mem mem_inst (
        .clk (clk), .rst_n (rst_n), .cen (cop_mem_cen), .wen (cop_mem_wen),
        .ben (cop_mem_ben), .wdata (cop_mem_wdata), .addr (cop_mem_addr),
        .stall (cop_mem_stall), .error (cop_mem_error), .rdata (cop_mem_rdata),
        .stall_cycles (stall_cycles), .err_en (err_en), .err_addr (err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;             // 10 ns period
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic rop_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};   // Weak low bits moved up
    endfunction

    function automatic rop_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rd);
        return {f7, 5'd12, 5'd11, `ROP_F3_R, rd, `ROP_ISE_OPCODE};
    endfunction

    function automatic rop_pkg::word_t enc_s(logic [11:0] imm);
        return {imm[11:5], 5'd12, 5'd11, `ROP_F3_SB_B, imm[4:0], `ROP_ISE_OPCODE};
    endfunction

    function automatic rop_pkg::word_t enc_i(logic [2:0] f3, logic [11:0] imm, logic [4:0] rd);
        return {imm, 5'd11, f3, rd, `ROP_ISE_OPCODE};
    endfunction

    task automatic check_word(input string name, input rop_pkg::word_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input rop_pkg::reg_idx_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte_sel(input string name, input rop_pkg::byte_sel_t got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic drive_req(input rop_pkg::word_t instr, rs1, rs2);
        @(negedge clk);
        cop_req      = 1'b1;
        cop_instr_in = instr;
        cop_rs1      = rs1;
        cop_rs2      = rs2;
    endtask

    task automatic release_req();
        @(negedge clk);
        cop_req = 1'b0;
    endtask

    // Polls cop_rsp just after each falling edge, bounded
    task automatic wait_rsp(output int cycles);
        cycles = 0;
        #1;
        while (!cop_rsp && cycles < RSP_TIMEOUT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!cop_rsp) begin
            errors++;
            $display("Timeout: no cop_rsp within %0d cycles", RSP_TIMEOUT);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------

    task automatic test_accept();
        rop_pkg::word_t members [9];
        rop_pkg::word_t others [4];
        members = '{enc_r(`ROP_F7_XOR_RB, 5), enc_r(`ROP_F7_XOR_RBK, 5),
                    enc_r(`ROP_F7_AND_RB, 5), enc_r(`ROP_F7_AND_RBK, 5),
                    enc_r(`ROP_F7_OR_RB, 5), enc_r(`ROP_F7_OR_RBK, 5), enc_s(12'h010),
                    enc_i(`ROP_F3_LB_B, 12'h020, 5), enc_i(`ROP_F3_LB_BK, 12'h030, 5)};
        others  = '{{enc_r(`ROP_F7_XOR_RB, 5)} ^ 32'h0000_0010,   // Other major opcode
                    {enc_r(`ROP_F7_XOR_RB, 5)} | 32'h0000_4000,   // funct3 101
                    enc_i(3'b111, 12'h000, 5),
                    enc_r(7'b1000000, 5)};                      // Unused funct7
        foreach (members[i]) begin
            drive_req(members[i], 32'h0000_0100, 32'h0000_0033);
            #1 check_bit("cop_acc", cop_acc, 1'b1);
            release_req();
        end
        foreach (others[i]) begin
            drive_req(others[i], lcg_next(), lcg_next());
            #1;
            check_bit("cop_acc", cop_acc, 1'b0);
            check_bit("cop_rsp", cop_rsp, 1'b0);
            check_bit("cop_wen", cop_wen, 1'b0);
            release_req();
        end
    endtask

    // Logic result low byte plus destination mapping for all six forms
    task automatic test_arith();
        logic [6:0] f7s [6];
        rop_pkg::word_t a, b;
        logic [4:0] rd;
        logic [7:0] exp;
        f7s = '{`ROP_F7_XOR_RB, `ROP_F7_XOR_RBK, `ROP_F7_AND_RB,
                `ROP_F7_AND_RBK, `ROP_F7_OR_RB, `ROP_F7_OR_RBK};
        for (int k = 0; k < 6; k++) begin
            a  = lcg_next();
            b  = lcg_next();
            rd = lcg_next() & 5'h1F;
            case (k / 2)
                0:       exp = a[7:0] ^ b[7:0];
                1:       exp = a[7:0] & b[7:0];
                default: exp = a[7:0] | b[7:0];
            endcase
            drive_req(enc_r(f7s[k], rd), a, b);
            #1;
            check_word("cop_wdata[7:0]", {24'h0, cop_wdata[7:0]}, {24'h0, exp});
            check_bit("cop_rsp", cop_rsp, 1'b1);
            check_bit("cop_wen", cop_wen, 1'b1);
            check_bit("clk_req", clk_req, 1'b1);
            if (k % 2) begin                // Keep forms go to a0..a7, whole word
                check_reg("cop_rd", cop_rd, 5'd10 + rd[2:0]);
                check_byte_sel("cop_rd_byte", cop_rd_byte, 3'd4);
            end else begin
                check_reg("cop_rd", cop_rd, rd);
                check_byte_sel("cop_rd_byte", cop_rd_byte, {1'b0, rd[4:3]});
            end
            release_req();
        end
    endtask

    task automatic test_padding();
        logic [23:0] pad [8];
        int same;
        same = 1;
        for (int i = 0; i < 8; i++) begin   // Back to back, req stays high
            drive_req(enc_r(`ROP_F7_XOR_RB, 3), 32'h0000_00C3, 32'h0000_005A);
            #1 pad[i] = cop_wdata[31:8];
            check_bit("cop_rsp", cop_rsp, 1'b1);
            if (pad[i] != pad[0]) same = 0;
        end
        release_req();
        checks++;
        if (same) begin
            errors++;
            $display("Padding bits of cop_wdata identical over eight requests");
        end
    endtask

    task automatic test_mem();
        rop_pkg::word_t rs1, rs2, ea, old, mask, exp_word;
        logic [11:0] imm;
        logic [3:0] ben_exp;
        int cycles;
        for (int s = 0; s < 4; s++) begin
            rs1 = lcg_next();
            rs2 = lcg_next();
            imm = lcg_next() & 12'hFFF;
            ea  = rs1 + {{20{imm[11]}}, imm};
            old = mem_inst.mem[ea[9:2]];
            mask = 32'hFF << (8 * ea[1:0]);
            exp_word = (old & ~mask) | (rs2 & mask);   // Only the addressed byte changes
            for (int k = 0; k < 4; k++) begin
                ben_exp[k] = (ea[1:0] == k);
            end
            stall_cycles = 0;
            drive_req(enc_s(imm), rs1, rs2);             // SB.B
            wait_rsp(cycles);
            check_word("cop_mem_addr", cop_mem_addr, {ea[31:2], 2'b00});
            check_word("cop_mem_ben", {28'h0, cop_mem_ben}, {28'h0, ben_exp});
            check_word("cop_mem_wdata", cop_mem_wdata, rs2);
            check_bit("cop_mem_cen", cop_mem_cen, 1'b1);
            check_bit("cop_mem_wen", cop_mem_wen, 1'b1);
            check_bit("cop_wen", cop_wen, 1'b0);
            release_req();
            check_word("model word", mem_inst.mem[ea[9:2]], exp_word);
            stall_cycles = s;
            drive_req(enc_i(`ROP_F3_LB_B, imm, 5'd9), rs1, rs2);
            wait_rsp(cycles);
            checks++;
            if (cycles != s) begin
                errors++;
                $display("LB.B response after %0d stall cycles, expected %0d", cycles, s);
            end
            check_word("cop_wdata", cop_wdata, exp_word);
            check_bit("cop_mem_wen", cop_mem_wen, 1'b0);
            check_bit("cop_wen", cop_wen, 1'b1);
            release_req();
        end
        stall_cycles = 0;
    endtask

    task automatic test_mem_error();
        rop_pkg::word_t rs1;
        int cycles;
        for (int st = 0; st < 2; st++) begin
            rs1      = lcg_next();
            err_addr = (rs1 + 32'd8) & 32'hFFFF_FFFC;
            err_en   = 1'b1;
            drive_req(st ? enc_s(12'd8) : enc_i(`ROP_F3_LB_B, 12'd8, 5'd4), rs1, 32'h77);
            wait_rsp(cycles);
            check_bit("cop_mem_ld_error", cop_mem_ld_error, st == 0);
            check_bit("cop_mem_st_error", cop_mem_st_error, st == 1);
            check_bit("cop_mem_cen", cop_mem_cen, 1'b0);
            check_bit("cop_rsp", cop_rsp, 1'b1);
            release_req();
            err_en = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        rst_n = 1'b0;
        cop_req = 1'b0;
        cop_instr_in = '0;
        cop_rs1 = '0;
        cop_rs2 = '0;
        stall_cycles = 0;
        err_en = 1'b0;
        err_addr = '0;
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        #1;
        check_bit("cop_acc", cop_acc, 1'b0);      // Idle after reset
        check_bit("cop_rsp", cop_rsp, 1'b0);
        check_bit("cop_wen", cop_wen, 1'b0);
        check_bit("cop_mem_cen", cop_mem_cen, 1'b0);
        check_bit("clk_req", clk_req, 1'b0);
        test_accept();
        test_arith();
        test_padding();
        test_mem();
        test_mem_error();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/rop_pkg.sv
logic/rop_dec_if.sv
logic/rop_decode.sv
logic/rop_prng.sv
logic/rop_execute.sv
logic/rop_result.sv
logic/rop_ba_cop.sv
testbench/tb_rop_mem.sv
testbench/tb_rop_ba_cop.sv
